//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int WORD_W = 32;            // Instruction and PC width

    // Recognized opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;  // R-type, funct selects op
    localparam logic [5:0] OP_J       = 6'b000010;  // Unconditional jump
    localparam logic [5:0] OP_LUI     = 6'b001111;  // Load upper immediate

    // Recognized funct codes under OP_SPECIAL
    localparam logic [5:0] FUNCT_ADDU = 6'b100001;
    localparam logic [5:0] FUNCT_SUBU = 6'b100011;

    // Field positions inside the instruction word
    localparam int OP_LSB    = 26;
    localparam int OP_W      = 6;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int REG_W     = 5;          // Register index width
    localparam int FUNCT_LSB = 0;
    localparam int FUNCT_W   = 6;
    localparam int IMM_LSB   = 0;
    localparam int IMM_W     = 16;
    localparam int JIDX_LSB  = 0;          // Jump word index starts at bit 0

    // ID/EX payload; valid leads so a zeroed struct is a bubble
    typedef struct packed {
        logic               valid;
        logic [WORD_W-1:0]  pc;
        logic [OP_W-1:0]    opcode;
        logic [REG_W-1:0]   rs;
        logic [REG_W-1:0]   rt;
        logic [REG_W-1:0]   rd;
        logic [FUNCT_W-1:0] funct;
        logic [IMM_W-1:0]   imm16;
        logic               is_jump;
    } decoded_t;

endpackage

`default_nettype wire

//--- hdl/front_pkg.sv
`default_nettype none

package front_pkg;

    localparam int IMEM_DEPTH = 16;                 // Instruction words
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH); // Word address width
    localparam int MEM_DW     = isa_pkg::WORD_W;    // Memory word, one instruction

    // Program loader handshake states
    typedef enum logic {
        LD_IDLE = 1'b0,                             // Waiting for req
        LD_ACK  = 1'b1                              // Ack held until req drops
    } load_state_t;

    // IF/ID payload; valid leads so a zeroed struct is a bubble
    typedef struct packed {
        logic              valid;
        logic [MEM_DW-1:0] pc;
        logic [MEM_DW-1:0] instr;
    } if_id_t;

endpackage

`default_nettype wire

//--- hdl/imem_loader.sv
`timescale 1ns/1ps
`default_nettype none

module imem_loader import front_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_load_req,      // Host request, four-phase
    input  logic [IMEM_AW-1:0] i_load_addr,     // Stable while req high
    input  logic [MEM_DW-1:0]  i_load_data,
    output logic               o_load_ack,
    output logic               o_we,            // One-cycle write strobe
    output logic [IMEM_AW-1:0] o_waddr,
    output logic [MEM_DW-1:0]  o_wdata
);

    load_state_t state;
    logic        start;                         // New transfer seen this cycle

    assign start = (state == LD_IDLE) && i_load_req;

    // Handshake FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: if (i_load_req)  state <= LD_ACK;   // Write and ack
                LD_ACK:  if (!i_load_req) state <= LD_IDLE;  // Host released
                default: state <= LD_IDLE;
            endcase
        end
    end

    // Strobe fires only on entry to LD_ACK, so a held req writes once
    always_ff @(posedge clk) begin
        if (rst) begin
            o_we <= 1'b0;
        end else begin
            o_we <= start;
        end
    end

    // Write payload, captured with the strobe
    always_ff @(posedge clk) begin
        if (start) begin
            o_waddr <= i_load_addr;
            o_wdata <= i_load_data;
        end
    end

    assign o_load_ack = (state == LD_ACK);     // Rises the edge after req

endmodule

`default_nettype wire

//--- hdl/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch import front_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_stall,     // Freezes the PC
    input  logic               i_redirect,  // Jump resolved in decode
    input  logic [IMEM_AW-1:0] i_target,    // Jump word address
    input  logic               i_we,        // Loader write strobe
    input  logic [IMEM_AW-1:0] i_waddr,
    input  logic [MEM_DW-1:0]  i_wdata,
    output logic [MEM_DW-1:0]  o_pc,
    output logic [MEM_DW-1:0]  o_instr
);

    logic [MEM_DW-1:0]  imem [IMEM_DEPTH];  // Instruction storage
    logic [IMEM_AW-1:0] pc;
    logic [IMEM_AW:0]   pc_inc;             // One extra bit to see the wrap
    logic [IMEM_AW-1:0] pc_seq;
    logic [IMEM_AW-1:0] pc_next;

    // Sequential successor, wraps to 0 past the last word
    assign pc_inc = {1'b0, pc} + 1'b1;

    always_comb begin
        if (pc_inc == (IMEM_AW+1)'(IMEM_DEPTH)) begin
            pc_seq = '0;
        end else begin
            pc_seq = pc_inc[IMEM_AW-1:0];
        end
    end

    // Jump wins over the sequential path
    assign pc_next = i_redirect ? i_target : pc_seq;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!i_stall) begin
            pc <= pc_next;                  // Hold while stalled
        end
    end

    // Loader port, writes allowed at any time
    always_ff @(posedge clk) begin
        if (i_we) begin
            imem[i_waddr] <= i_wdata;
        end
    end

    // Asynchronous read at the current PC
    assign o_instr = imem[pc];
    assign o_pc    = MEM_DW'(pc);           // Word index, zero extended

endmodule

`default_nettype wire

//--- hdl/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg import front_pkg::*; #(
    parameter type T = if_id_t              // Payload, valid in the MSB
) (
    input  logic clk,
    input  logic rst,
    input  logic i_stall,                   // Hold current entry
    input  logic i_flush,                   // Replace entry with a bubble
    input  T     i_d,
    output T     o_q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_q <= '0;                      // Whole payload, valid included
        end else if (!i_stall) begin
            if (i_flush) begin
                o_q <= '0;                  // Bubble, drops wrong-path entry
            end else begin
                o_q <= i_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import front_pkg::*;
    import isa_pkg::*;
(
    input  if_id_t             i_if_id,     // Entry from IF/ID register
    output decoded_t           o_dec,       // To ID/EX register
    output logic               o_redirect,  // Valid jump in IF/ID
    output logic [IMEM_AW-1:0] o_target     // Jump destination word
);

    logic [WORD_W-1:0] instr;
    logic              jump;

    assign instr = i_if_id.instr;
    assign jump  = (instr[OP_LSB +: OP_W] == OP_J);

    // Field split, fields passed raw whatever the format
    always_comb begin
        o_dec.valid   = i_if_id.valid;
        o_dec.pc      = i_if_id.pc;
        o_dec.opcode  = instr[OP_LSB +: OP_W];
        o_dec.rs      = instr[RS_LSB +: REG_W];
        o_dec.rt      = instr[RT_LSB +: REG_W];
        o_dec.rd      = instr[RD_LSB +: REG_W];
        o_dec.funct   = instr[FUNCT_LSB +: FUNCT_W];
        o_dec.imm16   = instr[IMM_LSB +: IMM_W];
        o_dec.is_jump = jump;               // Bubble has opcode 0, never a jump
    end

    // Redirect only for a real jump, never for a bubble
    assign o_redirect = i_if_id.valid && jump;

    // Memory is small, upper index bits are ignored
    assign o_target = instr[JIDX_LSB +: IMEM_AW];

endmodule

`default_nettype wire

//--- hdl/mips_front_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_front_top
    import front_pkg::*;
    import isa_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               i_stall,      // Global freeze
    input  logic               i_load_req,   // Program load port
    input  logic [IMEM_AW-1:0] i_load_addr,
    input  logic [MEM_DW-1:0]  i_load_data,
    output logic               o_load_ack,
    output logic               o_valid,      // ID/EX entry fields
    output logic [WORD_W-1:0]  o_pc,
    output logic [OP_W-1:0]    o_opcode,
    output logic [REG_W-1:0]   o_rs,
    output logic [REG_W-1:0]   o_rt,
    output logic [REG_W-1:0]   o_rd,
    output logic [FUNCT_W-1:0] o_funct,
    output logic [IMM_W-1:0]   o_imm,
    output logic               o_is_jump
);

    logic               we;
    logic [IMEM_AW-1:0] waddr;
    logic [MEM_DW-1:0]  wdata;
    logic [IMEM_AW-1:0] target;
    logic               jump_seen;       // Raw redirect from decode
    logic               redirect;        // Gated, only on a real advance
    if_id_t             if_d;
    if_id_t             if_q;
    decoded_t           dec;
    decoded_t           ex_q;

    imem_loader imem_loader_i (
        .clk         (clk),
        .rst         (rst),
        .i_load_req  (i_load_req),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_load_ack  (o_load_ack),
        .o_we        (we),
        .o_waddr     (waddr),
        .o_wdata     (wdata)
    );

    // Stalled jump waits in IF/ID and redirects once the stall lifts
    assign redirect = jump_seen && !i_stall;

    instruction_fetch instruction_fetch_i (
        .clk        (clk),
        .rst        (rst),
        .i_stall    (i_stall),
        .i_redirect (redirect),
        .i_target   (target),
        .i_we       (we),
        .i_waddr    (waddr),
        .i_wdata    (wdata),
        .o_pc       (if_d.pc),
        .o_instr    (if_d.instr)
    );

    assign if_d.valid = 1'b1;            // Fetch always has a word

    pipe_reg #(.T(if_id_t)) if_id_reg (
        .clk     (clk),
        .rst     (rst),
        .i_stall (i_stall),
        .i_flush (redirect),             // Kill the word behind the jump
        .i_d     (if_d),
        .o_q     (if_q)
    );

    instr_decode instr_decode_i (
        .i_if_id    (if_q),
        .o_dec      (dec),
        .o_redirect (jump_seen),
        .o_target   (target)
    );

    pipe_reg #(.T(decoded_t)) id_ex_reg (
        .clk     (clk),
        .rst     (rst),
        .i_stall (i_stall),
        .i_flush (1'b0),                 // Jump itself goes through
        .i_d     (dec),
        .o_q     (ex_q)
    );

    // Unpack ID/EX entry
    assign o_valid   = ex_q.valid;
    assign o_pc      = ex_q.pc;
    assign o_opcode  = ex_q.opcode;
    assign o_rs      = ex_q.rs;
    assign o_rt      = ex_q.rt;
    assign o_rd      = ex_q.rd;
    assign o_funct   = ex_q.funct;
    assign o_imm     = ex_q.imm16;
    assign o_is_jump = ex_q.is_jump;

endmodule

`default_nettype wire

//--- tests/mips_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_front_tb
    import front_pkg::*;
    import isa_pkg::*;
();

    localparam int RST_CYCLES  = 16;
    localparam int N_ROWS      = 56;                        // Stream table length
    localparam int WATCHDOG_NS = (N_ROWS + IMEM_DEPTH * 4 + 50) * 100;

    logic               clk = 1'b0;
    logic               rst;
    logic               i_stall;
    logic               i_load_req;
    logic [IMEM_AW-1:0] i_load_addr;
    logic [MEM_DW-1:0]  i_load_data;
    logic               o_load_ack;
    logic               o_valid;
    logic [WORD_W-1:0]  o_pc;
    logic [OP_W-1:0]    o_opcode;
    logic [REG_W-1:0]   o_rs;
    logic [REG_W-1:0]   o_rt;
    logic [REG_W-1:0]   o_rd;
    logic [FUNCT_W-1:0] o_funct;
    logic [IMM_W-1:0]   o_imm;
    logic               o_is_jump;

    logic [WORD_W-1:0]  prog [IMEM_DEPTH];                  // Program table
    bit                 row_stall [N_ROWS];                 // Stimulus column
    bit                 row_valid [N_ROWS];                 // Expected valid
    int                 row_pc    [N_ROWS];                 // Expected word address
    logic [15:0]        lfsr = 16'd9;                       // Seed
    int                 value_errors = 0;
    int                 flow_errors  = 0;
    int                 zero_seen    = 0;                   // Valid pc 0 outputs, wrap shows 2
    int                 jumps_seen   = 0;
    int                 stalls_seen  = 0;                   // Stalls that held a valid entry

    mips_front_top mips_front_top_i (.*);

    always #50 clk = ~clk;                                  // 100 ns period

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s expected %0h actual %0h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic fill_program();
        prog[0]  = {OP_LUI, 5'd0, 5'd1, 16'h1234};
        prog[1]  = {OP_LUI, 5'd0, 5'd2, 16'h00ff};
        prog[2]  = {OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, FUNCT_ADDU};
        prog[3]  = {OP_SPECIAL, 5'd3, 5'd1, 5'd4, 5'd0, FUNCT_SUBU};
        prog[4]  = {OP_LUI, 5'd0, 5'd5, 16'hbeef};
        prog[5]  = {OP_SPECIAL, 5'd5, 5'd4, 5'd6, 5'd0, FUNCT_ADDU};
        prog[6]  = {OP_SPECIAL, 5'd6, 5'd2, 5'd7, 5'd0, FUNCT_SUBU};
        prog[7]  = {OP_LUI, 5'd0, 5'd8, 16'h8001};
        prog[8]  = {OP_SPECIAL, 5'd8, 5'd7, 5'd9, 5'd0, FUNCT_ADDU};
        prog[9]  = {OP_J, 26'd12};                           // Jump over 10 and 11
        prog[10] = {OP_LUI, 5'd0, 5'd31, 16'hdead};          // Wrong path, never issued
        prog[11] = {OP_SPECIAL, 5'd31, 5'd31, 5'd10, 5'd0, FUNCT_ADDU};
        prog[12] = {OP_SPECIAL, 5'd9, 5'd3, 5'd11, 5'd0, FUNCT_SUBU};
        prog[13] = {OP_LUI, 5'd0, 5'd12, 16'h0f0f};
        prog[14] = {OP_SPECIAL, 5'd12, 5'd11, 5'd13, 5'd0, FUNCT_ADDU};
        prog[15] = {OP_SPECIAL, 5'd13, 5'd12, 5'd14, 5'd0, FUNCT_SUBU};
    endtask

    // Reference walk, one row per clock edge after reset release
    task automatic build_table();
        int          pc_walk;
        bit          bubble;
        bit          exp_v;
        int          exp_pc;
        bit          b0;
        logic [31:0] w;
        pc_walk = 0;
        bubble  = 1'b1;                                     // IF/ID still empty on first advance
        exp_v   = 1'b0;
        exp_pc  = 0;
        for (int k = 0; k < N_ROWS; k++) begin
            lfsr = lfsr_next(lfsr);
            b0   = lfsr[0];
            lfsr = lfsr_next(lfsr);
            row_stall[k] = b0 & lfsr[0];                    // About one stall in four
            if (!row_stall[k] && bubble) begin
                exp_v  = 1'b0;
                bubble = 1'b0;
            end else if (!row_stall[k]) begin
                w      = prog[pc_walk];
                exp_v  = 1'b1;
                exp_pc = pc_walk;
                if (w[31:26] == OP_J) begin
                    pc_walk = w[25:0] % IMEM_DEPTH;         // Next word is flushed
                    bubble  = 1'b1;
                end else begin
                    pc_walk = (pc_walk + 1) % IMEM_DEPTH;   // Wraps past the last word
                end
            end
            row_valid[k] = exp_v;                           // Stall keeps previous row
            row_pc[k]    = exp_pc;
        end
    endtask

    task automatic hold_reset(input bit stall_after);
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
            if (i == RST_CYCLES - 1) begin
                rst     <= 1'b0;
                i_stall <= stall_after;
            end
            @(negedge clk);
            if (o_valid !== 1'b0 || o_load_ack !== 1'b0) begin
                $display("o_valid or o_load_ack not low in reset cycle %0d", i);
                flow_errors++;
            end
        end
    endtask

    // Counts negedges until ack reaches level, 0 on timeout
    task automatic wait_ack(input logic level, input int addr, input string dir);
        int n;
        n = 0;
        for (int i = 1; i <= 8 && n == 0; i++) begin
            @(negedge clk);
            if (o_load_ack === level) n = i;
        end
        if (n == 0) begin
            $display("timed out waiting for ack to %s at address %0d", dir, addr);
            flow_errors++;
        end else begin
            check_val($sformatf("ack %s latency at address %0d", dir, addr), 2, n);
        end
    endtask

    task automatic load_word(input int addr);
        @(posedge clk);
        i_load_addr <= IMEM_AW'(addr);
        i_load_data <= prog[addr];
        i_load_req  <= 1'b1;
        wait_ack(1'b1, addr, "rise");
        @(posedge clk);
        i_load_req  <= 1'b0;                                // Addr and data held till here
        wait_ack(1'b0, addr, "fall");
    endtask

    task automatic check_row(input int k);
        logic [31:0] w;
        string       tag;
        w   = prog[row_pc[k]];
        tag = $sformatf("row %0d", k);
        check_val({tag, " o_valid"}, 32'(row_valid[k]), 32'(o_valid));
        if (row_valid[k]) begin
            check_val({tag, " o_pc"}, row_pc[k], o_pc);
            check_val({tag, " o_opcode"}, 32'(w[31:26]), 32'(o_opcode));
            check_val({tag, " o_rs"}, 32'(w[25:21]), 32'(o_rs));
            check_val({tag, " o_rt"}, 32'(w[20:16]), 32'(o_rt));
            check_val({tag, " o_rd"}, 32'(w[15:11]), 32'(o_rd));
            check_val({tag, " o_funct"}, 32'(w[5:0]), 32'(o_funct));
            check_val({tag, " o_imm"}, 32'(w[15:0]), 32'(o_imm));
            check_val({tag, " o_is_jump"}, 32'(w[31:26] == OP_J), 32'(o_is_jump));
        end
        if (row_stall[k]) begin
            if (o_valid === 1'b1) stalls_seen++;            // Entry held, fields compared
        end else if (o_valid === 1'b1) begin
            if (o_pc == 0) zero_seen++;
            if (o_is_jump === 1'b1) jumps_seen++;
            if (o_pc == 10) begin
                $display("address 10 behind the jump reached the outputs in row %0d", k);
                flow_errors++;
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        i_stall     = 1'b1;                                 // Core frozen while loading
        i_load_req  = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        fill_program();
        build_table();
        hold_reset(1'b1);
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            load_word(a);
        end
        @(posedge clk);
        rst <= 1'b1;                                        // Restart on the loaded program
        hold_reset(row_stall[0]);
        for (int k = 0; k < N_ROWS; k++) begin
            @(posedge clk);                                 // Edge that applies row k
            if (k + 1 < N_ROWS) i_stall <= row_stall[k+1];
            @(negedge clk);
            check_row(k);
        end
        if (stalls_seen == 0 || jumps_seen == 0 || zero_seen < 2) begin
            $display("stream incomplete, stalls %0d jumps %0d pc 0 outputs %0d",
                     stalls_seen, jumps_seen, zero_seen);
            flow_errors++;
        end
        $display("errors: %0d value, %0d flow", value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_front.f
hdl/isa_pkg.sv
hdl/front_pkg.sv
hdl/imem_loader.sv
hdl/instruction_fetch.sv
hdl/pipe_reg.sv
hdl/instr_decode.sv
hdl/mips_front_top.sv
tests/mips_front_tb.sv

//--- Bender.yml
package:
  name: mips_front

sources:
  - hdl/isa_pkg.sv
  - hdl/front_pkg.sv
  - hdl/imem_loader.sv
  - hdl/instruction_fetch.sv
  - hdl/pipe_reg.sv
  - hdl/instr_decode.sv
  - hdl/mips_front_top.sv
  - target: test
    files:
      - tests/mips_front_tb.sv
